//--- histo_pkg.sv
package histo_pkg;

    ////////////////////////////////////////////////////////////
    // Sample side.
    ////////////////////////////////////////////////////////////

    // One photon pulse count.
    localparam int SAMPLE_W = 16;

    ////////////////////////////////////////////////////////////
    // GRAM side.
    ////////////////////////////////////////////////////////////

    localparam int GRAM_ADDR_W  = 24;                       // Pixel address.
    localparam int PIXEL_W      = 16;                       // RGB565.
    localparam int BURST_PIXELS = 4;                        // Pixels per write.
    localparam int BURST_W      = PIXEL_W * BURST_PIXELS;   // Pixel 0 in low bits.

    // Palette, RGB565.
    localparam logic [PIXEL_W-1:0] COLOR_BAR        = 16'hF81F;   // Pink.
    localparam logic [PIXEL_W-1:0] COLOR_BACKGROUND = 16'h0000;   // Black.

endpackage : histo_pkg

//--- hist_if.sv
`timescale 1ns/1ps

// Link between the sample ring and the bar painter.
interface hist_if;
    import histo_pkg::*;

    logic                frame_start;   // One-cycle pulse, redraw begins.
    logic [SAMPLE_W-1:0] sample;        // Sample for the current row.
    logic                next;          // Advance read pointer one slot.
    logic                busy;          // Redraw in progress.

    // Ring buffer side.
    modport history (
        output frame_start,
        output sample,
        input  next,
        input  busy
    );

    // Painter side.
    modport painter (
        input  frame_start,
        input  sample,
        output next,
        output busy
    );

endinterface : hist_if

//--- scan_if.sv
`timescale 1ns/1ps

// Link between the raster scanner and the bar painter.
interface scan_if;
    import histo_pkg::*;

    logic                   restart;        // Back to row 0, burst 0.
    logic                   step;           // Advance one burst.
    logic [GRAM_ADDR_W-1:0] burst_addr;     // First pixel of the burst.
    // Offset in sample units, compared against the bar length.
    logic [SAMPLE_W-1:0]    burst_offset;
    logic                   row_end;        // Last burst of a row.
    logic                   frame_end;      // Last burst of last row.

    modport scanner (
        input  restart,
        input  step,
        output burst_addr,
        output burst_offset,
        output row_end,
        output frame_end
    );

    modport painter (
        output restart,
        output step,
        input  burst_addr,
        input  burst_offset,
        input  row_end,
        input  frame_end
    );

endinterface : scan_if

//--- sample_history.sv
`timescale 1ns/1ps

module sample_history #(
    parameter int N_POINTS = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          sample_valid,
    input  logic [histo_pkg::SAMPLE_W-1:0] sample,
    hist_if.history                       hist
);
    import histo_pkg::*;

    localparam int PTR_W = (N_POINTS > 1) ? $clog2(N_POINTS) : 1;

    ////////////////////////////////////////////////////////////
    // Storage and pointers.
    ////////////////////////////////////////////////////////////

    logic [SAMPLE_W-1:0] slot [N_POINTS];   // Flop ring, oldest at wr_head.
    logic [PTR_W-1:0]    wr_head;           // Next slot to overwrite.
    logic [PTR_W-1:0]    wr_head_nxt;
    logic [PTR_W-1:0]    rd_ptr;            // Slot shown to the painter.
    logic                pending;           // One redraw owed.
    logic                start_now;

    // Ring increment with wrap.
    function automatic logic [PTR_W-1:0] ring_inc(input logic [PTR_W-1:0] p);
        ring_inc = (p == PTR_W'(N_POINTS - 1)) ? '0 : p + 1'b1;
    endfunction

    always_comb begin
        wr_head_nxt = sample_valid ? ring_inc(wr_head) : wr_head;
    end

    // Frame_start counts as busy, painter sees it one cycle late.
    always_comb begin
        start_now = !hist.busy && !hist.frame_start && (sample_valid || pending);
    end

    ////////////////////////////////////////////////////////////
    // Sample write, also during a redraw.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_POINTS; i++) begin
                slot[i] <= '0;                          // Empty history.
            end
        end else if (sample_valid) begin
            slot[wr_head] <= sample;
        end
    end

    ////////////////////////////////////////////////////////////
    // Head, read pointer, frame trigger.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_head          <= '0;
            rd_ptr           <= '0;
            pending          <= 1'b0;
            hist.frame_start <= 1'b0;
        end else begin
            wr_head          <= wr_head_nxt;
            hist.frame_start <= start_now;              // One-cycle pulse.
            // Collapse any number of late samples into one redraw.
            if (start_now) begin
                pending <= 1'b0;
            end else if (sample_valid) begin
                pending <= 1'b1;
            end
            // Oldest sample sits at the new head.
            if (start_now) begin
                rd_ptr <= wr_head_nxt;
            end else if (hist.next) begin
                rd_ptr <= ring_inc(rd_ptr);
            end
        end
    end

    assign hist.sample = slot[rd_ptr];                  // Valid cycle after move.

endmodule : sample_history

//--- raster_scanner.sv
`timescale 1ns/1ps

module raster_scanner #(
    parameter int N_POINTS    = 16,
    parameter int BAR_PIXELS  = 32,
    parameter int LINE_PIXELS = 64,
    parameter int GRAM_ORIGIN = 100
) (
    input  logic clk,
    input  logic rst_n,
    scan_if.scanner scan
);
    import histo_pkg::*;

    localparam int ROW_W = (N_POINTS > 1) ? $clog2(N_POINTS) : 1;

    // Offset of the last burst in a row.
    localparam logic [SAMPLE_W-1:0] LAST_OFFSET = SAMPLE_W'(BAR_PIXELS - BURST_PIXELS);
    localparam logic [ROW_W-1:0]    LAST_ROW    = ROW_W'(N_POINTS - 1);

    logic [ROW_W-1:0]       row_cnt;    // Plot row, 0 is oldest.
    logic [SAMPLE_W-1:0]    offset;     // Pixel offset in row.
    logic [GRAM_ADDR_W-1:0] row_base;   // First pixel of row.
    logic                   row_end;
    logic                   frame_end;

    assign row_end   = (offset == LAST_OFFSET);
    assign frame_end = row_end && (row_cnt == LAST_ROW);

    ////////////////////////////////////////////////////////////
    // Burst walk.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt  <= '0;
            offset   <= '0;
            row_base <= GRAM_ADDR_W'(GRAM_ORIGIN);
        end else if (scan.restart) begin
            row_cnt  <= '0;
            offset   <= '0;
            row_base <= GRAM_ADDR_W'(GRAM_ORIGIN);
        end else if (scan.step) begin
            if (!row_end) begin
                offset <= offset + SAMPLE_W'(BURST_PIXELS);   // Next 4 pixels.
            end else begin
                offset <= '0;
                if (frame_end) begin
                    // Back to top of plot.
                    row_cnt  <= '0;
                    row_base <= GRAM_ADDR_W'(GRAM_ORIGIN);
                end else begin
                    row_cnt  <= row_cnt + 1'b1;
                    row_base <= row_base + GRAM_ADDR_W'(LINE_PIXELS);   // Line stride.
                end
            end
        end
    end

    assign scan.burst_addr   = row_base + GRAM_ADDR_W'(offset);
    assign scan.burst_offset = offset;
    assign scan.row_end      = row_end;
    assign scan.frame_end    = frame_end;

endmodule : raster_scanner

//--- bar_painter.sv
`timescale 1ns/1ps

module bar_painter #(
    parameter int BAR_PIXELS = 32
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [1:0]                       gain_shift,
    hist_if.painter                          hist,
    scan_if.painter                          scan,
    output logic                             gram_wr_req,
    output logic [histo_pkg::GRAM_ADDR_W-1:0] gram_wr_addr,
    output logic [histo_pkg::BURST_W-1:0]     gram_wr_data,
    input  logic                             gram_wr_done,
    output logic                             frame_done,
    output logic [histo_pkg::SAMPLE_W-1:0]    frame_max,
    output logic [histo_pkg::SAMPLE_W-1:0]    frame_min
);
    import histo_pkg::*;

    // FSM state codes.
    localparam logic [2:0] ST_IDLE  = 3'd0;   // Waiting for frame_start.
    localparam logic [2:0] ST_ROW   = 3'd1;   // Latch sample, bar length.
    localparam logic [2:0] ST_LOAD  = 3'd2;   // Present a burst.
    localparam logic [2:0] ST_WRITE = 3'd3;   // Hold request until done.
    localparam logic [2:0] ST_WAIT  = 3'd4;   // Read pointer settles.

    localparam logic [SAMPLE_W-1:0] BAR_MAX   = SAMPLE_W'(BAR_PIXELS);
    localparam logic [SAMPLE_W-1:0] BURST_TOP = SAMPLE_W'(BURST_PIXELS - 1);

    logic [2:0]          state;
    logic [SAMPLE_W-1:0] bar_len;       // Pixels of bar in this row.
    logic [SAMPLE_W-1:0] run_max;       // Extremes so far this frame.
    logic [SAMPLE_W-1:0] run_min;
    logic [SAMPLE_W-1:0] shifted;
    logic [SAMPLE_W-1:0] clipped;
    logic                fill_bar;

    ////////////////////////////////////////////////////////////
    // Scale, clip, colour decision.
    ////////////////////////////////////////////////////////////

    always_comb begin
        shifted  = hist.sample >> gain_shift;               // Divide by 1,2,4,8.
        clipped  = (shifted > BAR_MAX) ? BAR_MAX : shifted;
        // Whole burst inside the bar, else background.
        fill_bar = (scan.burst_offset + BURST_TOP) < bar_len;
    end

    assign scan.restart = (state == ST_IDLE) && hist.frame_start;
    assign scan.step    = (state == ST_WRITE) && gram_wr_done;
    assign hist.next    = scan.step && scan.row_end && !scan.frame_end;

    ////////////////////////////////////////////////////////////
    // Control.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            gram_wr_req <= 1'b0;
            hist.busy   <= 1'b0;
            frame_done  <= 1'b0;
            frame_max   <= '0;
            frame_min   <= '1;
            run_max     <= '0;
            run_min     <= '1;
        end else begin
            frame_done <= 1'b0;                             // Pulse.
            case (state)
                ST_IDLE: begin
                    if (hist.frame_start) begin
                        hist.busy <= 1'b1;
                        run_max   <= '0;
                        run_min   <= '1;
                        state     <= ST_ROW;
                    end
                end
                ST_ROW: begin
                    // Fold the raw count, not the scaled one.
                    if (hist.sample > run_max) run_max <= hist.sample;
                    if (hist.sample < run_min) run_min <= hist.sample;
                    state <= ST_LOAD;
                end
                ST_LOAD: begin
                    gram_wr_req <= 1'b1;
                    state       <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (gram_wr_done) begin
                        gram_wr_req <= 1'b0;                // Drop after done.
                        if (scan.frame_end) begin
                            frame_done <= 1'b1;
                            frame_max  <= run_max;
                            frame_min  <= run_min;
                            hist.busy  <= 1'b0;
                            state      <= ST_IDLE;
                        end else if (scan.row_end) begin
                            state <= ST_WAIT;
                        end else begin
                            state <= ST_LOAD;
                        end
                    end
                end
                ST_WAIT: state <= ST_ROW;                   // New sample valid.
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Payload.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_ROW) begin
            bar_len <= clipped;                             // Gain taken per row.
        end
        if (state == ST_LOAD) begin
            gram_wr_addr <= scan.burst_addr;
            gram_wr_data <= fill_bar ? {BURST_PIXELS{COLOR_BAR}}
                                     : {BURST_PIXELS{COLOR_BACKGROUND}};
        end
    end

endmodule : bar_painter

//--- histo_scroll_top.sv
`timescale 1ns/1ps

module histo_scroll_top #(
    parameter int N_POINTS    = 16,     // Plot rows.
    parameter int BAR_PIXELS  = 32,     // Bar line width, multiple of 4.
    parameter int LINE_PIXELS = 64,     // GRAM line stride.
    parameter int GRAM_ORIGIN = 100     // First plot pixel.
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // New pulse count.
    input  logic                             sample_valid,
    input  logic [histo_pkg::SAMPLE_W-1:0]    sample,
    input  logic [1:0]                       gain_shift,
    // GRAM write port.
    output logic                             gram_wr_req,
    output logic [histo_pkg::GRAM_ADDR_W-1:0] gram_wr_addr,
    output logic [histo_pkg::BURST_W-1:0]     gram_wr_data,
    input  logic                             gram_wr_done,
    // Per-frame window statistics.
    output logic                             frame_done,
    output logic [histo_pkg::SAMPLE_W-1:0]    frame_max,
    output logic [histo_pkg::SAMPLE_W-1:0]    frame_min
);

    hist_if u_hist_if ();
    scan_if u_scan_if ();

    // History ring.
    sample_history #(
        .N_POINTS     (N_POINTS)
    ) u_sample_history (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .hist         (u_hist_if.history)
    );

    // Burst address walk.
    raster_scanner #(
        .N_POINTS    (N_POINTS),
        .BAR_PIXELS  (BAR_PIXELS),
        .LINE_PIXELS (LINE_PIXELS),
        .GRAM_ORIGIN (GRAM_ORIGIN)
    ) u_raster_scanner (
        .clk         (clk),
        .rst_n       (rst_n),
        .scan        (u_scan_if.scanner)
    );

    // Combines both into GRAM writes.
    bar_painter #(
        .BAR_PIXELS   (BAR_PIXELS)
    ) u_bar_painter (
        .clk          (clk),
        .rst_n        (rst_n),
        .gain_shift   (gain_shift),
        .hist         (u_hist_if.painter),
        .scan         (u_scan_if.painter),
        .gram_wr_req  (gram_wr_req),
        .gram_wr_addr (gram_wr_addr),
        .gram_wr_data (gram_wr_data),
        .gram_wr_done (gram_wr_done),
        .frame_done   (frame_done),
        .frame_max    (frame_max),
        .frame_min    (frame_min)
    );

endmodule : histo_scroll_top

//--- tb_histo_scroll.sv
`timescale 1ns/1ps

module tb_histo_scroll;

    localparam int N_POINTS    = 16;
    localparam int BAR_PIXELS  = 32;
    localparam int LINE_PIXELS = 64;
    localparam int GRAM_ORIGIN = 100;
    localparam int ROW_BURSTS  = BAR_PIXELS / 4;
    localparam int BURSTS      = N_POINTS * ROW_BURSTS;     // Writes per frame.
    // About 28 frames of at most 128 bursts of 6 cycles, with margin.
    localparam int MAX_CYCLES  = 40000;
    localparam logic [15:0] BAR_COLOR = 16'hF81F;
    localparam logic [15:0] BG_COLOR  = 16'h0000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        sample_valid;
    logic [15:0] sample;
    logic [1:0]  gain_shift;
    logic        gram_wr_req;
    logic [23:0] gram_wr_addr;
    logic [63:0] gram_wr_data;
    logic        gram_wr_done = 1'b0;
    logic        frame_done;
    logic [15:0] frame_max;
    logic [15:0] frame_min;

    logic [15:0] ring [N_POINTS];       // Expected history, oldest at ring_head.
    int          ring_head;
    logic [63:0] plot_mem [BURSTS];     // GRAM contents of the plot area.
    int          write_tag [BURSTS];    // Frame number plus one of last write.
    int          total_writes;
    int          writes_mark;           // Write count at the last frame end.
    int          frame_cnt;
    int          err_main;
    int          err_gram;
    int          err_check;
    int          cycle_cnt;
    int          wait_left = -1;        // Cycles until done, -1 when idle.
    logic [31:0] delay_state = 32'h1188_75fd;
    logic [31:0] stim_state  = 32'h1188_75fd;
    logic        skip_content;          // History changed under this frame.

    histo_scroll_top #(
        .N_POINTS    (N_POINTS),
        .BAR_PIXELS  (BAR_PIXELS),
        .LINE_PIXELS (LINE_PIXELS),
        .GRAM_ORIGIN (GRAM_ORIGIN)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .gain_shift   (gain_shift),
        .gram_wr_req  (gram_wr_req),
        .gram_wr_addr (gram_wr_addr),
        .gram_wr_data (gram_wr_data),
        .gram_wr_done (gram_wr_done),
        .frame_done   (frame_done),
        .frame_max    (frame_max),
        .frame_min    (frame_min)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Shift, clip, then a burst is bar only if all four pixels fit.
    function automatic logic [63:0] expected_burst(input int row, input int off);
        logic [15:0] s;
        int          bar;
        s   = ring[(ring_head + row) % N_POINTS];
        bar = int'(s >> gain_shift);
        if (bar > BAR_PIXELS) begin
            bar = BAR_PIXELS;
        end
        expected_burst = (off + 3 < bar) ? {4{BAR_COLOR}} : {4{BG_COLOR}};
    endfunction

    function automatic int error_total();
        error_total = err_main + err_gram + err_check;
    endfunction

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // GRAM model.
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        int rel;
        int idx;
        #2;
        if (gram_wr_done) begin
            gram_wr_done = 1'b0;                            // Taken at this edge.
        end else if (gram_wr_req) begin
            if (wait_left < 0) begin
                delay_state = lcg_next(delay_state);
                wait_left   = int'(delay_state[17:16]) + 1; // 1 to 4 cycles.
            end
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                wait_left    = -1;
                gram_wr_done = 1'b1;
                total_writes = total_writes + 1;
                rel = int'(gram_wr_addr) - GRAM_ORIGIN;
                if (rel < 0 || rel / LINE_PIXELS >= N_POINTS ||
                    rel % LINE_PIXELS >= BAR_PIXELS || rel % 4 != 0) begin
                    $display("write outside the plot area at address %h", gram_wr_addr);
                    err_gram++;
                end else begin
                    idx = (rel / LINE_PIXELS) * ROW_BURSTS + (rel % LINE_PIXELS) / 4;
                    if (write_tag[idx] == frame_cnt + 1) begin
                        $display("address %h written twice in one frame", gram_wr_addr);
                        err_gram++;
                    end
                    write_tag[idx] = frame_cnt + 1;
                    plot_mem[idx]  = gram_wr_data;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame checker, frame_done is stable at the falling edge.
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [15:0] exp_max;
        logic [15:0] exp_min;
        logic [63:0] exp_data;
        if (rst_n && frame_done) begin
            if (total_writes - writes_mark != BURSTS) begin
                $display("frame %0d had %0d writes instead of %0d",
                         frame_cnt, total_writes - writes_mark, BURSTS);
                err_check++;
            end
            writes_mark = total_writes;
            if (!skip_content) begin
                exp_max = 16'h0000;
                exp_min = 16'hFFFF;
                for (int i = 0; i < N_POINTS; i++) begin
                    if (ring[i] > exp_max) exp_max = ring[i];
                    if (ring[i] < exp_min) exp_min = ring[i];
                end
                for (int b = 0; b < BURSTS; b++) begin
                    exp_data = expected_burst(b / ROW_BURSTS, (b % ROW_BURSTS) * 4);
                    if (write_tag[b] != frame_cnt + 1) begin
                        $display("frame %0d left burst %0d unwritten", frame_cnt, b);
                        err_check++;
                    end else if (plot_mem[b] !== exp_data) begin
                        $display("[FAIL] gram_wr_data row %0d offset %0d exp %h got %h",
                                 b / ROW_BURSTS, (b % ROW_BURSTS) * 4, exp_data, plot_mem[b]);
                        err_check++;
                    end
                end
                if (frame_max !== exp_max) begin
                    $display("[FAIL] frame_max exp %h got %h", exp_max, frame_max);
                    err_check++;
                end
                if (frame_min !== exp_min) begin
                    $display("[FAIL] frame_min exp %h got %h", exp_min, frame_min);
                    err_check++;
                end
            end
            frame_cnt++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus.
    ////////////////////////////////////////////////////////////

    task automatic send_sample(input logic [15:0] v);
        @(posedge clk);
        #2;
        sample_valid    = 1'b1;
        sample          = v;
        ring[ring_head] = v;                                // Mirror the history.
        ring_head       = (ring_head + 1) % N_POINTS;
        @(posedge clk);
        #2;
        sample_valid = 1'b0;
    endtask

    task automatic wait_frames(input int target);
        while (frame_cnt < target) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_and_draw(input logic [15:0] v);
        int target;
        target = frame_cnt + 1;
        send_sample(v);
        wait_frames(target);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (error_total() == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_total() - err_before);
        end
    endtask

    initial begin
        int          errs;
        int          base;
        int          base_w;
        logic [15:0] v;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = 16'h0000;
        gain_shift   = 2'd0;
        skip_content = 1'b0;
        for (int i = 0; i < N_POINTS; i++) begin
            ring[i] = 16'h0000;                             // History starts empty.
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        errs = error_total();
        repeat (50) begin
            @(posedge clk);
            #2;
            if (gram_wr_req !== 1'b0) begin
                $display("[FAIL] gram_wr_req exp %h got %h", 1'b0, gram_wr_req);
                err_main++;
            end
            if (frame_done !== 1'b0) begin
                $display("[FAIL] frame_done exp %h got %h", 1'b0, frame_done);
                err_main++;
            end
        end
        if (frame_max !== 16'h0000) begin
            $display("[FAIL] frame_max exp %h got %h", 16'h0000, frame_max);
            err_main++;
        end
        if (frame_min !== 16'hFFFF) begin
            $display("[FAIL] frame_min exp %h got %h", 16'hFFFF, frame_min);
            err_main++;
        end
        report_test("1 idle after reset", errs);

        errs       = error_total();
        gain_shift = 2'd1;
        send_and_draw(16'd21);                              // Bar of 10 pixels.
        report_test("2 single sample", errs);

        errs       = error_total();
        gain_shift = 2'd0;
        for (int i = 0; i < N_POINTS + 5; i++) begin
            stim_state = lcg_next(stim_state);
            // Mostly near the bar width, now and then a full-range count.
            v = (stim_state[27:24] == 4'h0) ? stim_state[31:16]
                                            : {10'h000, stim_state[21:16]};
            send_and_draw(v);
        end
        report_test("3 scroll and wrap", errs);

        errs = error_total();
        for (int g = 0; g < 4; g++) begin
            gain_shift = 2'(g);
            send_and_draw(16'hFFFF >> (4 * g));
        end
        report_test("4 gain and clip", errs);

        errs       = error_total();
        gain_shift = 2'd2;
        base       = frame_cnt;
        base_w     = total_writes;
        send_sample(16'd1234);
        while (total_writes < base_w + 20) begin
            @(posedge clk);
        end
        skip_content = 1'b1;                                // Ring moves mid-frame.
        send_sample(16'd7);
        repeat (3) @(posedge clk);
        send_sample(16'd4000);
        wait_frames(base + 1);
        skip_content = 1'b0;
        wait_frames(base + 2);
        // Room for one more whole frame at the slowest GRAM.
        repeat (BURSTS * 6) @(posedge clk);
        if (frame_cnt != base + 2) begin
            $display("expected one extra frame after busy samples, saw %0d",
                     frame_cnt - base - 1);
            err_main++;
        end
        report_test("5 samples during a frame", errs);

        $display("frames %0d, writes %0d, errors %0d", frame_cnt, total_writes, error_total());
        if (error_total() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_histo_scroll

//--- filelist.f
histo_pkg.sv
hist_if.sv
scan_if.sv
sample_history.sv
raster_scanner.sv
bar_painter.sv
histo_scroll_top.sv
tb_histo_scroll.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_histo_scroll
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
